// ==== src/pipelineCfgPkg.sv ====
package pipelineCfgPkg;

    // Monotone Boolean functions of seven variables
    localparam int varCount = 7;

    // One truth table covers every point of the hypercube
    localparam int funcBits = 1 << varCount;

    // The ports carry the truth table as two halves
    localparam int halfBits = funcBits / 2;

    // Running sum and wrapping count of nonzero pcoeffs
    localparam int sumBits = 38;
    localparam int countBits = 3;
    localparam int compBits = 7;

    // Result word layout, sum at bit 0 and count at bit 48
    localparam int outWordBits = 64;
    localparam int countLsb = 48;

endpackage

// ==== src/boolFuncPkg.sv ====
package boolFuncPkg;

    import pipelineCfgPkg::*;

    // ******************************
    // Truth table views
    // ******************************

    // Upper half first so that it lands in the high bits of the vector
    typedef struct packed {
        logic [halfBits-1:0] upper;
        logic [halfBits-1:0] lower;
    } funcHalves;

    // Same 128 bits, as one vector for logic or as the port halves
    typedef union packed {
        logic [funcBits-1:0] bits;
        funcHalves halves;
    } boolFunc;

    // ******************************
    // Stage to stage transfers
    // ******************************

    // A bot on its way to the counter, flagged when it opens a new top
    typedef struct packed {
        logic newTop;
        boolFunc bot;
    } botJob;

    // Counter output, underTop low means the pcoeff is zero
    typedef struct packed {
        logic newTop;
        logic underTop;
        logic [compBits-1:0] compCount;
    } countResult;

endpackage

// ==== src/botInputStage.sv ====
`timescale 1ns/1ps

module botInputStage (
    input  logic clk,
    input  logic rst,
    input  logic ivalid,
    input  logic startNewTop,
    input  boolFuncPkg::boolFunc inWord,
    output logic oready,
    output boolFuncPkg::boolFunc curTop,
    output logic jobValid,
    output boolFuncPkg::botJob job,
    input  logic busy
);

    import boolFuncPkg::*;

    logic accept;
    logic acceptBot;
    logic canIssue;
    logic bufValid;
    logic pendingNewTop;
    botJob bufJob;

    assign oready = !bufValid;
    assign accept = ivalid && oready;
    assign acceptBot = accept && !startNewTop;

    // The counter raises busy one edge after it sees jobValid, so the
    // cycle with jobValid high must not issue again
    assign canIssue = !busy && !jobValid;

    // ******************************
    // Control
    // ******************************

    always_ff @(posedge clk) begin
        if (!rst) begin
            bufValid <= 1'b0;
            pendingNewTop <= 1'b0;
            jobValid <= 1'b0;
            curTop <= '0;
        end else begin
            jobValid <= 1'b0;
            if (accept && startNewTop) begin
                curTop <= inWord;
                pendingNewTop <= 1'b1;
            end
            if (bufValid && canIssue) begin
                jobValid <= 1'b1;
                bufValid <= 1'b0;
            end else if (acceptBot) begin
                // Bypass the buffer when the counter can take the bot right away
                jobValid <= canIssue;
                bufValid <= !canIssue;
                pendingNewTop <= 1'b0;
            end
        end
    end

    // ******************************
    // Payload
    // ******************************

    always_ff @(posedge clk) begin
        if (bufValid && canIssue) begin
            job <= bufJob;
        end else if (acceptBot) begin
            if (canIssue) begin
                job <= '{newTop: pendingNewTop, bot: inWord};
            end else begin
                bufJob <= '{newTop: pendingNewTop, bot: inWord};
            end
        end
    end

endmodule

// ==== src/componentCounter.sv ====
`timescale 1ns/1ps

module componentCounter (
    input  logic clk,
    input  logic rst,
    input  logic jobValid,
    input  boolFuncPkg::botJob job,
    input  boolFuncPkg::boolFunc curTop,
    output logic busy,
    output logic resultValid,
    output boolFuncPkg::countResult result
);

    import pipelineCfgPkg::*;
    import boolFuncPkg::*;

    logic loadPhase;
    logic growPhase;
    logic newTopReg;
    boolFunc botReg;
    boolFunc topReg;
    logic [funcBits-1:0] remaining;
    logic [funcBits-1:0] comp;
    logic [funcBits-1:0] neighbours;
    logic [funcBits-1:0] grown;
    logic [funcBits-1:0] lowestBit;
    logic [compBits-1:0] compCount;
    logic underTop;
    logic takeJob;
    logic loadStep;
    logic seedStep;
    logic growStep;
    logic stable;
    logic report;

    // Phase decode, busy with neither flag set is the seed step
    assign takeJob = jobValid && !busy;
    assign loadStep = busy && loadPhase;
    assign growStep = busy && growPhase;
    assign seedStep = busy && !loadPhase && !growPhase;

    assign underTop = ~|(botReg.bits & ~topReg.bits);
    assign lowestBit = remaining & (~remaining + 1'b1);

    // ******************************
    // Hypercube neighbourhood
    // ******************************

    // Point i touches i with one of its seven index bits flipped
    always_comb begin
        for (int i = 0; i < funcBits; i++) begin
            neighbours[i] = 1'b0;
            for (int d = 0; d < varCount; d++) begin
                neighbours[i] = neighbours[i] | comp[i ^ (1 << d)];
            end
        end
    end

    assign grown = comp | (neighbours & remaining);
    assign stable = (grown == comp);

    // Not under the top ends right after the load, otherwise the empty set does
    assign report = (loadStep && !underTop) || (seedStep && remaining == '0);

    // ******************************
    // Control
    // ******************************

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            loadPhase <= 1'b0;
            growPhase <= 1'b0;
            resultValid <= 1'b0;
            compCount <= '0;
        end else begin
            resultValid <= report;
            if (takeJob) begin
                busy <= 1'b1;
                loadPhase <= 1'b1;
            end else if (report) begin
                busy <= 1'b0;
                loadPhase <= 1'b0;
            end else if (loadStep) begin
                loadPhase <= 1'b0;
                compCount <= '0;
            end else if (growStep) begin
                if (stable) begin
                    growPhase <= 1'b0;
                    compCount <= compCount + 1'b1;
                end
            end else if (seedStep) begin
                growPhase <= 1'b1;
            end
        end
    end

    // ******************************
    // Payload
    // ******************************

    always_ff @(posedge clk) begin
        if (takeJob) begin
            botReg <= job.bot;
            topReg <= curTop;
            newTopReg <= job.newTop;
        end
        if (loadStep) begin
            remaining <= topReg.bits & ~botReg.bits;
        end
        if (seedStep) begin
            comp <= lowestBit;
        end
        if (growStep) begin
            // A finished component leaves the remaining set
            if (stable) begin
                remaining <= remaining & ~comp;
            end else begin
                comp <= grown;
            end
        end
        if (report) begin
            result.newTop <= newTopReg;
            result.underTop <= underTop;
            result.compCount <= underTop ? compCount : '0;
        end
    end

endmodule

// ==== src/pcoeffAccumulator.sv ====
`timescale 1ns/1ps

module pcoeffAccumulator (
    input  logic clk,
    input  logic rst,
    input  logic resultValid,
    input  boolFuncPkg::countResult result,
    output logic ovalid,
    output logic [pipelineCfgPkg::outWordBits-1:0] outWord
);

    import pipelineCfgPkg::*;

    logic [sumBits-1:0] runSum;
    logic [sumBits-1:0] baseSum;
    logic [sumBits-1:0] pcoeff;
    logic [countBits-1:0] runCount;
    logic [countBits-1:0] baseCount;

    // ******************************
    // Pcoeff and per-top restart
    // ******************************

    always_comb begin
        // Shifts past the sum width drop out, same as the wrapping add
        if (result.underTop) begin
            pcoeff = sumBits'(1) << result.compCount;
        end else begin
            pcoeff = '0;
        end
        // A new top starts from zero before its first bot is added
        baseSum = result.newTop ? '0 : runSum;
        baseCount = result.newTop ? '0 : runCount;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ovalid <= 1'b0;
            runSum <= '0;
            runCount <= '0;
        end else begin
            ovalid <= resultValid;
            if (resultValid) begin
                runSum <= baseSum + pcoeff;
                // The true pcoeff is nonzero exactly when the bot is under the top
                runCount <= baseCount + countBits'(result.underTop);
            end
        end
    end

    // ******************************
    // Output word
    // ******************************

    always_comb begin
        outWord = '0;
        outWord[sumBits-1:0] = runSum;
        outWord[countLsb +: countBits] = runCount;
    end

endmodule

// ==== src/dedekindPipelineTop.sv ====
`timescale 1ns/1ps

module dedekindPipelineTop (
    input  logic clk,
    input  logic rst,
    input  logic ivalid,
    input  logic startNewTop,
    input  logic [pipelineCfgPkg::halfBits-1:0] botLower,
    input  logic [pipelineCfgPkg::halfBits-1:0] botUpper,
    output logic oready,
    output logic ovalid,
    output logic [pipelineCfgPkg::outWordBits-1:0] summedDataPcoeffCountOut
);

    import boolFuncPkg::*;

    boolFunc inWord;
    boolFunc curTop;
    botJob job;
    countResult result;
    logic jobValid;
    logic busy;
    logic resultValid;

    // The offered word arrives as two port halves
    assign inWord.halves = '{upper: botUpper, lower: botLower};

    botInputStage inputStage (
        .clk(clk),
        .rst(rst),
        .ivalid(ivalid),
        .startNewTop(startNewTop),
        .inWord(inWord),
        .oready(oready),
        .curTop(curTop),
        .jobValid(jobValid),
        .job(job),
        .busy(busy)
    );

    componentCounter counter (
        .clk(clk),
        .rst(rst),
        .jobValid(jobValid),
        .job(job),
        .curTop(curTop),
        .busy(busy),
        .resultValid(resultValid),
        .result(result)
    );

    pcoeffAccumulator accumulator (
        .clk(clk),
        .rst(rst),
        .resultValid(resultValid),
        .result(result),
        .ovalid(ovalid),
        .outWord(summedDataPcoeffCountOut)
    );

endmodule

// ==== verification/dedekindPipelineTb_assert.sv ====
`timescale 1ns/1ps

module dedekindPipelineChecks (
    input logic clk,
    input logic rst,
    input logic ivalid,
    input logic startNewTop,
    input logic oready,
    input logic ovalid
);

    int outstanding;
    int errorCount = 0;

    // Bots taken in but not yet answered
    always_ff @(posedge clk) begin
        if (!rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(ivalid && oready && !startNewTop) - int'(ovalid);
        end
    end

    // ******************************
    // Protocol properties
    // ******************************

    resultPulse: assert property (@(posedge clk) disable iff (!rst) ovalid |=> !ovalid)
        else begin
            errorCount++;
            $error("ovalid stayed high for more than one cycle");
        end

    readyAfterReset: assert property (@(posedge clk) !rst |=> oready)
        else begin
            errorCount++;
            $error("oready was low right after reset");
        end

    resultHasBot: assert property (@(posedge clk) disable iff (!rst) ovalid |-> outstanding > 0)
        else begin
            errorCount++;
            $error("ovalid came without an accepted bot waiting for it");
        end

endmodule

bind dedekindPipelineTop dedekindPipelineChecks protocolChecks (
    .clk(clk),
    .rst(rst),
    .ivalid(ivalid),
    .startNewTop(startNewTop),
    .oready(oready),
    .ovalid(ovalid)
);

// ==== verification/dedekindPipelineTb.sv ====
`timescale 1ns/1ps

module dedekindPipelineTb;

    import pipelineCfgPkg::*;

    localparam int topCount = 10;
    localparam int botsPerTop = 12;
    localparam int directedWords = 13;
    localparam int totalWords = directedWords + topCount * (botsPerTop + 1);
    localparam int cycleLimit = 40 * totalWords + 200;

    logic clk;
    logic rst;
    logic ivalid;
    logic startNewTop;
    logic [halfBits-1:0] botLower;
    logic [halfBits-1:0] botUpper;
    logic oready;
    logic ovalid;
    logic [outWordBits-1:0] summedDataPcoeffCountOut;

    logic [31:0] rngState = 32'hd962_06d5;
    logic [funcBits-1:0] modelTop = '0;
    logic [sumBits-1:0] modelSum = '0;
    logic [countBits-1:0] modelCount = '0;
    logic [outWordBits-1:0] expected[$];
    logic [outWordBits-1:0] expWord;
    int resultIndex = 0;
    int cycleCount = 0;
    logic sawStall = 1'b0;

    dedekindPipelineTop DUT (
        .clk(clk),
        .rst(rst),
        .ivalid(ivalid),
        .startNewTop(startNewTop),
        .botLower(botLower),
        .botUpper(botUpper),
        .oready(oready),
        .ovalid(ovalid),
        .summedDataPcoeffCountOut(summedDataPcoeffCountOut)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abortRun();
        $display("sim failed");
        $fatal(1, "Run stopped at %0t ns", $time);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [funcBits-1:0] randWord();
        logic [funcBits-1:0] w;
        for (int k = 0; k < funcBits / 32; k++) begin
            rngState = xorshift(rngState);
            w[32*k +: 32] = rngState;
        end
        return w;
    endfunction

    // Every point above a seed point belongs to the function
    function automatic logic [funcBits-1:0] upClosure(input logic [funcBits-1:0] seed);
        logic [funcBits-1:0] f;
        f = '0;
        for (int j = 0; j < funcBits; j++) begin
            for (int i = 0; i < funcBits; i++) begin
                if (seed[i] && ((j & i) == i)) begin
                    f[j] = 1'b1;
                end
            end
        end
        return f;
    endfunction

    // Depth-first search over points one index bit apart
    function automatic int countComponents(input logic [funcBits-1:0] rem);
        logic [funcBits-1:0] left;
        int stack[$];
        int n;
        int p;
        left = rem;
        n = 0;
        for (int s = 0; s < funcBits; s++) begin
            if (left[s]) begin
                n++;
                left[s] = 1'b0;
                stack.push_back(s);
                while (stack.size() > 0) begin
                    p = stack.pop_back();
                    for (int d = 0; d < varCount; d++) begin
                        if (left[p ^ (1 << d)]) begin
                            left[p ^ (1 << d)] = 1'b0;
                            stack.push_back(p ^ (1 << d));
                        end
                    end
                end
            end
        end
        return n;
    endfunction

    // Odd-parity points never touch each other, so each one is its own component
    function automatic logic [funcBits-1:0] oddPoints(input int limit);
        logic [funcBits-1:0] m;
        int k;
        m = '0;
        k = 0;
        for (int i = 0; i < funcBits; i++) begin
            if (^7'(i) && k < limit) begin
                m[i] = 1'b1;
                k++;
            end
        end
        return m;
    endfunction

    // ******************************
    // Driver and reference model
    // ******************************

    task automatic offerWord(input logic isTop, input logic [funcBits-1:0] w);
        logic [sumBits-1:0] pcoeff;
        logic [outWordBits-1:0] exp;
        ivalid = 1'b1;
        startNewTop = isTop;
        {botUpper, botLower} = w;
        @(negedge clk);
        while (!oready) begin
            sawStall = 1'b1;
            @(negedge clk);
        end
        if (isTop) begin
            modelTop = w;
            modelSum = '0;
            modelCount = '0;
        end else begin
            if ((w & ~modelTop) == '0) begin
                // Shifts past the sum width give zero, so the sum wraps at 2^38
                pcoeff = sumBits'(1) << countComponents(modelTop & ~w);
                modelSum = modelSum + pcoeff;
                modelCount = modelCount + 1'b1;
            end
            exp = '0;
            exp[sumBits-1:0] = modelSum;
            exp[countLsb +: countBits] = modelCount;
            expected.push_back(exp);
        end
        @(posedge clk);
        #1;
        ivalid = 1'b0;
    endtask

    initial begin
        logic [funcBits-1:0] top;
        logic [funcBits-1:0] bot;
        logic [funcBits-1:0] pick;
        rst = 1'b0;
        ivalid = 1'b0;
        startNewTop = 1'b0;
        botLower = '0;
        botUpper = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;

        // Equal bot adds one, a bot holding point zero is outside this top
        top = upClosure((funcBits'(1) << 7) | (funcBits'(1) << 48));
        offerWord(1'b1, top);
        offerWord(1'b0, top);
        offerWord(1'b0, funcBits'(1));

        for (int t = 0; t < topCount; t++) begin
            top = upClosure(randWord() & randWord() & randWord() & randWord());
            offerWord(1'b1, top);
            for (int b = 0; b < botsPerTop; b++) begin
                pick = randWord();
                if (pick[2:0] == 3'd0) begin
                    bot = top;
                end else if (pick[2:0] == 3'd1) begin
                    bot = top | pick;
                end else begin
                    bot = top & ~(randWord() & randWord() & randWord());
                end
                offerWord(1'b0, bot);
                repeat (int'(pick[4:3])) begin
                    @(posedge clk);
                    #1;
                end
            end
        end

        // 37 isolated points twice wrap the sum, then a long checkerboard bot
        // with words queued behind it, pushing the count past seven
        offerWord(1'b1, '1);
        repeat (3) offerWord(1'b0, ~oddPoints(37));
        offerWord(1'b0, ~oddPoints(64));
        repeat (5) offerWord(1'b0, '1);

        while (expected.size() > 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        #1;
        if (!sawStall) begin
            $display("oready never fell while a word was being offered");
            abortRun();
        end else begin
            $display("sim passed");
            $finish;
        end
    end

    // ******************************
    // Result checking and watchdog
    // ******************************

    always @(negedge clk) begin
        if (DUT.protocolChecks.errorCount != 0) begin
            $display("A protocol assertion on the DUT failed");
            abortRun();
        end else if (rst && ovalid) begin
            if (expected.size() == 0) begin
                $display("A result came out with no bot left to answer");
                abortRun();
            end else begin
                expWord = expected.pop_front();
                resultIndex++;
                assert (summedDataPcoeffCountOut == expWord)
                    else begin
                        $display("** Error at %0t ns: result %0d is %h, expected %h",
                                 $time, resultIndex, summedDataPcoeffCountOut, expWord);
                        abortRun();
                    end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles with %0d results still missing",
                     cycleCount, expected.size());
            abortRun();
        end
    end

endmodule

// ==== build.f ====
src/pipelineCfgPkg.sv
src/boolFuncPkg.sv
src/botInputStage.sv
src/componentCounter.sv
src/pcoeffAccumulator.sv
src/dedekindPipelineTop.sv
verification/dedekindPipelineTb_assert.sv
verification/dedekindPipelineTb.sv

// ==== Bender.yml ====
package:
  name: dedekind_pipeline

sources:
  # Packages first, the stages use their types and constants
  - src/pipelineCfgPkg.sv
  - src/boolFuncPkg.sv
  - src/botInputStage.sv
  - src/componentCounter.sv
  - src/pcoeffAccumulator.sv
  - src/dedekindPipelineTop.sv
  - target: simulation
    files:
      - verification/dedekindPipelineTb_assert.sv
      - verification/dedekindPipelineTb.sv
